// File: project.f
src/piso_pkg.sv
src/block_dispatch.sv
src/piso_lane.sv
src/chunk_collect.sv
src/piso_bank_top.sv
tb/piso_bank_checker.sv
tb/tb_piso_bank.sv

// File: src/block_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module block_dispatch (
  input  logic                               clk,
  input  logic                               rst_b,
  input  logic                               zeroize_i,

  // Upstream block stream
  input  logic                               valid_i,
  output logic                               hold_o,
  input  piso_pkg::block_t                   data_i,

  // Streams towards the lanes
  output logic [piso_pkg::NUM_LANES-1:0]     lane_valid_o,
  input  logic [piso_pkg::NUM_LANES-1:0]     lane_hold_i,
  output piso_pkg::block_t                   lane_data_o
);

  piso_pkg::lane_sel_t wr_idx;
  logic                accept;

  // Only the indexed lane can stall the upstream source
  always_comb begin
    hold_o = lane_hold_i[wr_idx];
  end

  always_comb begin
    accept = valid_i & ~hold_o;
  end

  // Valid goes to one lane at a time
  always_comb begin
    for (int i = 0; i < piso_pkg::NUM_LANES; i++) begin
      lane_valid_o[i] = valid_i && (wr_idx == piso_pkg::lane_sel_t'(i));
    end
  end

  // Block data is shared, lanes ignore it unless their valid is set
  always_comb begin
    lane_data_o = data_i;
  end

  // Round-robin write index, moves on accepted blocks only
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_idx <= '0;
    end else if (zeroize_i) begin
      wr_idx <= '0;
    end else if (accept) begin
      if (wr_idx == piso_pkg::lane_sel_t'(piso_pkg::NUM_LANES - 1)) begin
        wr_idx <= '0;
      end else begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/chunk_collect.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_collect (
  input  logic                                         clk,
  input  logic                                         rst_b,
  input  logic                                         zeroize_i,
  input  piso_pkg::mode_t                              mode_i,

  // Streams from the lanes
  input  logic [piso_pkg::NUM_LANES-1:0]               lane_valid_i,
  output logic [piso_pkg::NUM_LANES-1:0]               lane_hold_o,
  input  piso_pkg::chunk_t [piso_pkg::NUM_LANES-1:0]   lane_data_i,

  // Merged chunk stream
  output logic                                         valid_o,
  input  logic                                         hold_i,
  output piso_pkg::chunk_t                             data_o
);

  piso_pkg::lane_sel_t rd_idx;
  piso_pkg::ptr_t      chunk_cnt;
  piso_pkg::ptr_t      last_cnt;
  logic                accept;

  // Count value of the final chunk of a block in this mode
  always_comb begin
    last_cnt = piso_pkg::ptr_t'(piso_pkg::CHUNKS_PER_BLOCK[mode_i] - 1);
  end

  // Read side follows the indexed lane
  always_comb begin
    valid_o = lane_valid_i[rd_idx];
    data_o  = lane_data_i[rd_idx];
  end

  // Lanes not being drained are held so their chunks wait in order
  always_comb begin
    for (int i = 0; i < piso_pkg::NUM_LANES; i++) begin
      if (rd_idx == piso_pkg::lane_sel_t'(i)) begin
        lane_hold_o[i] = hold_i;
      end else begin
        lane_hold_o[i] = 1'b1;
      end
    end
  end

  always_comb begin
    accept = valid_o & ~hold_i;
  end

  // One block worth of chunks per lane, then on to the next lane
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rd_idx    <= '0;
      chunk_cnt <= '0;
    end else if (zeroize_i) begin
      rd_idx    <= '0;
      chunk_cnt <= '0;
    end else if (accept) begin
      if (chunk_cnt == last_cnt) begin
        chunk_cnt <= '0;
        if (rd_idx == piso_pkg::lane_sel_t'(piso_pkg::NUM_LANES - 1)) begin
          rd_idx <= '0;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end else begin
        chunk_cnt <= chunk_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/piso_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module piso_bank_top (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  piso_pkg::mode_t   mode_i,

  // Wide block input
  input  logic              valid_i,
  output logic              hold_o,
  input  piso_pkg::block_t  data_i,

  // Narrow chunk output
  output logic              valid_o,
  input  logic              hold_i,
  output piso_pkg::chunk_t  data_o
);

  // Dispatcher to lanes
  logic [piso_pkg::NUM_LANES-1:0]             in_valid;
  logic [piso_pkg::NUM_LANES-1:0]             in_hold;
  piso_pkg::block_t                           in_data;

  // Lanes to collector
  logic [piso_pkg::NUM_LANES-1:0]             out_valid;
  logic [piso_pkg::NUM_LANES-1:0]             out_hold;
  piso_pkg::chunk_t [piso_pkg::NUM_LANES-1:0] out_data;

  block_dispatch block_dispatch_inst (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .valid_i      (valid_i),
    .hold_o       (hold_o),
    .data_i       (data_i),
    .lane_valid_o (in_valid),
    .lane_hold_i  (in_hold),
    .lane_data_o  (in_data)
  );

  // Identical lanes, filled and drained in round-robin order
  for (genvar i = 0; i < piso_pkg::NUM_LANES; i++) begin : g_lane
    piso_lane piso_lane_inst (
      .clk       (clk),
      .rst_b     (rst_b),
      .zeroize_i (zeroize_i),
      .mode_i    (mode_i),
      .valid_i   (in_valid[i]),
      .hold_o    (in_hold[i]),
      .data_i    (in_data),
      .valid_o   (out_valid[i]),
      .hold_i    (out_hold[i]),
      .data_o    (out_data[i])
    );
  end

  chunk_collect chunk_collect_inst (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .mode_i       (mode_i),
    .lane_valid_i (out_valid),
    .lane_hold_o  (out_hold),
    .lane_data_i  (out_data),
    .valid_o      (valid_o),
    .hold_i       (hold_i),
    .data_o       (data_o)
  );

endmodule

`default_nettype wire

// File: src/piso_lane.sv
`timescale 1ns/1ps
`default_nettype none

module piso_lane (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  piso_pkg::mode_t   mode_i,

  // Block input
  input  logic              valid_i,
  output logic              hold_o,
  input  piso_pkg::block_t  data_i,

  // Chunk output
  output logic              valid_o,
  input  logic              hold_i,
  output piso_pkg::chunk_t  data_o
);

  localparam int BUF_W = piso_pkg::BUF_W;
  localparam int IN_W  = piso_pkg::IN_W;

  logic [BUF_W-1:0] buffer;
  logic [BUF_W-1:0] buffer_d;
  logic [BUF_W-1:0] wr_data;
  logic [BUF_W-1:0] wr_mask;
  piso_pkg::ptr_t   wr_ptr;
  piso_pkg::ptr_t   wr_ptr_d;
  piso_pkg::ptr_t   in_rate;
  piso_pkg::ptr_t   out_rate;
  piso_pkg::chunk_t out_mask;
  logic             buf_wr;
  logic             buf_rd;

  // Rate pair for the current mode
  always_comb begin
    in_rate  = piso_pkg::ptr_t'(piso_pkg::IN_RATES[mode_i]);
    out_rate = piso_pkg::ptr_t'(piso_pkg::OUT_RATES[mode_i]);
  end

  // Stall once another full block would overflow the buffer
  always_comb begin
    hold_o = wr_ptr > (piso_pkg::ptr_t'(BUF_W) - in_rate);
  end

  // A chunk is ready when at least out_rate bits are stored
  always_comb begin
    valid_o = wr_ptr >= out_rate;
  end

  // Bits above the output rate are forced to zero
  always_comb begin
    out_mask = piso_pkg::chunk_t'({piso_pkg::OUT_W{1'b1}} >>
                                  (piso_pkg::ptr_t'(piso_pkg::OUT_W) - out_rate));
    data_o   = buffer[piso_pkg::OUT_W-1:0] & out_mask;
  end

  always_comb begin
    buf_wr = valid_i & ~hold_o;
    buf_rd = valid_o & ~hold_i;
  end

  // Keep only the input-rate bits of the incoming block
  always_comb begin
    wr_mask = {BUF_W{1'b1}} >> (piso_pkg::ptr_t'(BUF_W) - in_rate);
    wr_data = {{(BUF_W - IN_W){1'b0}}, data_i} & wr_mask;
  end

  // Next pointer and buffer, a read shifts first and the write lands above
  always_comb begin
    unique case ({buf_rd, buf_wr})
      2'b01: begin
        wr_ptr_d = wr_ptr + in_rate;
        buffer_d = (wr_data << wr_ptr) | buffer;
      end
      2'b10: begin
        wr_ptr_d = wr_ptr - out_rate;
        buffer_d = buffer >> out_rate;
      end
      2'b11: begin
        wr_ptr_d = wr_ptr + (in_rate - out_rate);
        buffer_d = (wr_data << (wr_ptr - out_rate)) | (buffer >> out_rate);
      end
      default: begin
        wr_ptr_d = wr_ptr;
        buffer_d = buffer;
      end
    endcase
  end

  // Empty space above the pointer must stay zero for the OR merge
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buffer <= '0;
      wr_ptr <= '0;
    end else if (zeroize_i) begin
      buffer <= '0;
      wr_ptr <= '0;
    end else if (buf_wr || buf_rd) begin
      buffer <= buffer_d;
      wr_ptr <= wr_ptr_d;
    end
  end

endmodule

`default_nettype wire

// File: src/piso_pkg.sv
`default_nettype none

package piso_pkg;

  // Bank geometry
  localparam int NUM_LANES = 4;
  localparam int NUM_MODES = 4;

  // Lane buffer and port widths
  localparam int BUF_W = 96;
  localparam int IN_W  = 64;
  localparam int OUT_W = 16;

  // Pointer width covers the full buffer depth and every rate
  localparam int PTR_W = 7;

  // Input rate per mode
  localparam int IN_RATES [NUM_MODES] = '{64, 64, 48, 48};

  // Output rate per mode
  localparam int OUT_RATES [NUM_MODES] = '{16, 8, 16, 12};

  // Chunks carried by one input block, input rate over output rate
  localparam int CHUNKS_PER_BLOCK [NUM_MODES] = '{4, 8, 3, 4};

  // Rate pair select
  typedef logic [1:0] mode_t;

  // Input block, only the low input-rate bits are used
  typedef logic [IN_W-1:0] block_t;

  // Output chunk, only the low output-rate bits are meaningful
  typedef logic [OUT_W-1:0] chunk_t;

  // Lane index for the round-robin steering
  typedef logic [1:0] lane_sel_t;

  // Buffer write pointer, rates and chunk counts
  typedef logic [PTR_W-1:0] ptr_t;

endpackage

`default_nettype wire

// File: tb/piso_bank_checker.sv
`timescale 1ns/1ps
`default_nettype none

module piso_bank_checker (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  piso_pkg::mode_t   mode_i,

  // Input stream of the DUT
  input  logic              in_valid_i,
  input  logic              in_hold_i,
  input  piso_pkg::block_t  in_data_i,

  // Output stream of the DUT
  input  logic              out_valid_i,
  input  logic              out_hold_i,
  input  piso_pkg::chunk_t  out_data_i,

  // Test sequencing from the testbench top
  input  int                test_num_i,
  input  logic              test_end_i,
  output int                err_count_o,
  output int                tests_failed_o,
  output int                pending_bits_o
);

  // Bits accepted at the input and not yet seen at the output, LSB first
  bit   bit_q[$];
  int   err_total    = 0;
  int   failed_total = 0;
  int   pending      = 0;
  int   test_errs    = 0;
  int   blocks_in    = 0;
  int   chunks_out   = 0;
  int   chunks_exp   = 0;
  int   reset_cycles = 0;
  logic post_reset   = 1'b0;
  logic zeroize_q    = 1'b0;
  logic hold_seen    = 1'b0;

  assign err_count_o    = err_total;
  assign tests_failed_o = failed_total;
  assign pending_bits_o = pending;

  // Input rate in bits for each mode
  function automatic int in_bits(input piso_pkg::mode_t mode);
    case (mode)
      2'd0, 2'd1: return 64;
      default:    return 48;
    endcase
  endfunction

  // Output rate in bits for each mode
  function automatic int out_bits(input piso_pkg::mode_t mode);
    case (mode)
      2'd0:    return 16;
      2'd1:    return 8;
      2'd2:    return 16;
      default: return 12;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[ERROR] time %0t: %s", $time, msg);
    test_errs++;
    err_total++;
  endtask

  task automatic report_problem(input string msg);
    $display("Test %0d went wrong: %s", test_num_i, msg);
    test_errs++;
    err_total++;
  endtask

  // Pop one chunk worth of bits and compare the meaningful part of data_o
  task automatic check_chunk();
    int               n;
    piso_pkg::chunk_t exp;
    piso_pkg::chunk_t mask;
    n    = out_bits(mode_i);
    exp  = '0;
    mask = '0;
    if (bit_q.size() < n) begin
      report_problem($sformatf("a chunk came out with only %0d input bits waiting",
                               bit_q.size()));
      bit_q.delete();
    end else begin
      for (int i = 0; i < n; i++) begin
        exp[i]  = bit_q.pop_front();
        mask[i] = 1'b1;
      end
      if (((out_data_i ^ exp) & mask) != '0) begin
        report_mismatch($sformatf("chunk %0d is %h, expected %h",
                                  chunks_out, out_data_i & mask, exp));
      end
    end
  endtask

  task automatic close_test();
    if (chunks_out != chunks_exp) begin
      report_mismatch($sformatf("test %0d gave %0d chunks, expected %0d",
                                test_num_i, chunks_out, chunks_exp));
    end
    if (bit_q.size() != 0) begin
      report_problem($sformatf("%0d input bits never reached the output", bit_q.size()));
    end
    if (test_num_i == 3 && !hold_seen) begin
      report_problem("hold_o never rose while the output was stalled");
    end
    if (test_errs == 0) begin
      $display("test %0d passed: %0d blocks in, %0d chunks out",
               test_num_i, blocks_in, chunks_out);
    end else begin
      $display("test %0d failed with %0d errors", test_num_i, test_errs);
      failed_total++;
    end
    test_errs  = 0;
    blocks_in  = 0;
    chunks_out = 0;
    chunks_exp = 0;
    hold_seen  = 1'b0;
  endtask

  always @(posedge clk) begin
    if (!rst_b) begin
      // First edge of reset may still see unknown state
      if (reset_cycles > 0 && (out_valid_i !== 1'b0 || in_hold_i !== 1'b0)) begin
        report_mismatch($sformatf("valid_o %b hold_o %b in reset, expected 0 0",
                                  out_valid_i, in_hold_i));
      end
      reset_cycles++;
      bit_q.delete();
      post_reset = 1'b1;
      zeroize_q  = 1'b0;
    end else begin
      if ((post_reset || zeroize_q) && (out_valid_i !== 1'b0 || in_hold_i !== 1'b0)) begin
        report_mismatch($sformatf("valid_o %b hold_o %b after clear, expected 0 0",
                                  out_valid_i, in_hold_i));
      end
      post_reset = 1'b0;
      if (in_hold_i) begin
        hold_seen = 1'b1;
      end
      if (zeroize_i) begin
        // Everything still buffered is dropped
        bit_q.delete();
        chunks_exp = chunks_out;
      end else begin
        if (out_valid_i && !out_hold_i) begin
          check_chunk();
          chunks_out++;
        end
        if (in_valid_i && !in_hold_i) begin
          for (int i = 0; i < in_bits(mode_i); i++) begin
            bit_q.push_back(in_data_i[i]);
          end
          blocks_in++;
          chunks_exp += in_bits(mode_i) / out_bits(mode_i);
        end
      end
      zeroize_q = zeroize_i;
    end
    if (test_end_i) begin
      close_test();
    end
    pending = bit_q.size();
  end

endmodule

`default_nettype wire

// File: tb/tb_piso_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_piso_bank;

  // Worst case is 8 chunks per block, stretched by output stalls
  localparam int TOTAL_BLOCKS = 64 + 3 * 48 + 48 + 20 + 24;
  localparam int CYCLE_LIMIT  = TOTAL_BLOCKS * 8 * 4 + 2000;

  logic             clk;
  logic             rst_b;
  logic             zeroize_i;
  piso_pkg::mode_t  mode_i;
  logic             valid_i;
  logic             hold_o;
  piso_pkg::block_t data_i;
  logic             valid_o;
  logic             hold_i;
  piso_pkg::chunk_t data_o;

  int   test_num;
  logic test_end;
  int   err_count;
  int   tests_failed;
  int   pending_bits;
  int   cycle_cnt;

  piso_bank_top piso_bank_top_inst (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .mode_i    (mode_i),
    .valid_i   (valid_i),
    .hold_o    (hold_o),
    .data_i    (data_i),
    .valid_o   (valid_o),
    .hold_i    (hold_i),
    .data_o    (data_o)
  );

  piso_bank_checker piso_bank_checker_inst (
    .clk            (clk),
    .rst_b          (rst_b),
    .zeroize_i      (zeroize_i),
    .mode_i         (mode_i),
    .in_valid_i     (valid_i),
    .in_hold_i      (hold_o),
    .in_data_i      (data_i),
    .out_valid_i    (valid_o),
    .out_hold_i     (hold_i),
    .out_data_i     (data_o),
    .test_num_i     (test_num),
    .test_end_i     (test_end),
    .err_count_o    (err_count),
    .tests_failed_o (tests_failed),
    .pending_bits_o (pending_bits)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAIL");
    $finish;
  end

  // Random blocks with a 75% valid duty, optional random output stalls
  task automatic send_blocks(input int n, input bit rand_hold);
    int sent;
    bit taken;
    sent  = 0;
    taken = 1'b0;
    while (sent < n) begin
      @(negedge clk);
      hold_i = rand_hold ? ($urandom_range(0, 1) == 1) : 1'b0;
      if (taken) begin
        valid_i = 1'b0;
      end
      if (!valid_i && $urandom_range(0, 3) != 0) begin
        valid_i = 1'b1;
        data_i  = {$urandom, $urandom};
      end
      // hold_o only depends on registered state here
      taken = valid_i && !hold_o;
      if (taken) begin
        sent++;
      end
    end
    @(negedge clk);
    valid_i = 1'b0;
    hold_i  = 1'b0;
  endtask

  task automatic zeroize_pulse(input piso_pkg::mode_t mode);
    @(negedge clk);
    zeroize_i = 1'b1;
    mode_i    = mode;
    valid_i   = 1'b0;
    hold_i    = 1'b0;
    @(negedge clk);
    zeroize_i = 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (pending_bits != 0 || valid_o);
  endtask

  task automatic end_test();
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    rst_b     = 1'b0;
    zeroize_i = 1'b0;
    mode_i    = 2'd0;
    valid_i   = 1'b0;
    data_i    = '0;
    hold_i    = 1'b0;
    test_num  = 4;
    test_end  = 1'b0;
    void'($urandom(32'hbd3b_4a2a));

    // Reset state
    repeat (5) @(negedge clk);
    rst_b = 1'b1;
    repeat (3) @(negedge clk);
    end_test();

    // Mode 0, no stalls
    test_num = 1;
    send_blocks(64, 1'b0);
    wait_drain();
    end_test();

    // Remaining rate pairs
    test_num = 2;
    for (int m = 1; m < 4; m++) begin
      zeroize_pulse(piso_pkg::mode_t'(m));
      send_blocks(48, 1'b0);
      wait_drain();
    end
    end_test();

    // Output stalls in mode 3
    test_num = 3;
    send_blocks(48, 1'b1);
    wait_drain();
    end_test();

    // Clear with data still in the lanes
    test_num = 5;
    send_blocks(20, 1'b1);
    zeroize_pulse(2'd3);
    send_blocks(24, 1'b1);
    wait_drain();
    end_test();

    @(negedge clk);
    $display("Tests run: 5, failed: %0d, errors: %0d", tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
